// ==== cpu8008_config.svh ====
`ifndef CPU8008_CONFIG_SVH
`define CPU8008_CONFIG_SVH

// Width of the external byte bus and every scratch register
`define CPU_DATA_W 8

// Program counter width, 16K of program space
`define CPU_ADDR_W 14

// Scratch registers A, B, C, D, E, H, L
`define CPU_NUM_REGS 7

// Address stack entries, one of them always holds the PC
`define CPU_STACK_DEPTH 8

`endif

// ==== cpu8008_isa_pkg.sv ====
`include "cpu8008_config.svh"

package cpu8008_isa_pkg;

	typedef logic [`CPU_DATA_W-1:0] data_t;
	typedef logic [`CPU_ADDR_W-1:0] addr_t;

	// Index 0 is the accumulator and the top index is the null slot
	typedef logic [$clog2(`CPU_NUM_REGS + 1)-1:0] reg_idx_t;

	typedef logic [$clog2(`CPU_STACK_DEPTH)-1:0] stack_ptr_t;

	// Codes match the state pins of the original part
	typedef enum logic [2:0] {
		t1     = 3'b010,
		t2     = 3'b100,
		t_wait = 3'b000,
		t3     = 3'b001,
		t4     = 3'b111,
		t5     = 3'b101
	} t_state_e;

	// Sent in the two top bits of the T2 byte
	typedef enum logic [1:0] {
		fetch = 2'b00,
		read  = 2'b01
	} cycle_type_e;

	// The first eight follow the PPP field of the 10PPPSSS opcodes
	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_adc  = 4'd1,
		alu_sub  = 4'd2,
		alu_sbb  = 4'd3,
		alu_and  = 4'd4,
		alu_xor  = 4'd5,
		alu_or   = 4'd6,
		alu_cmp  = 4'd7,
		alu_inc  = 4'd8,
		alu_dec  = 4'd9,
		alu_pass = 4'd10,
		alu_rlc  = 4'd12, // Rotates follow the RR field of 000RR010
		alu_rrc  = 4'd13,
		alu_ral  = 4'd14,
		alu_rar  = 4'd15
	} alu_op_e;

endpackage

// ==== cpu8008_ctrl_pkg.sv ====
package cpu8008_ctrl_pkg;

	typedef enum logic [2:0] {
		src_none     = 3'd0,
		src_pc_low   = 3'd1,
		src_pc_high  = 3'd2,
		src_reg_file = 3'd3,
		src_alu      = 3'd4,
		src_tmp_b    = 3'd5,
		src_d_in     = 3'd6
	} bus_src_e;

	typedef struct packed {
		logic                      we;
		cpu8008_isa_pkg::reg_idx_t idx; // Also selects the read port
	} rf_ctrl_t;

	typedef struct packed {
		cpu8008_isa_pkg::alu_op_e op;
		logic                     load_tmp_a;
		logic                     load_tmp_b;
		logic                     write_carry;
	} alu_ctrl_t;

	typedef struct packed {
		logic push;
		logic pop;
		logic inc_pc;
		logic load_target;
	} stack_ctrl_t;

	typedef struct packed {
		bus_src_e    bus_src;
		rf_ctrl_t    rf;
		alu_ctrl_t   alu;
		stack_ctrl_t stack;
	} cpu_ctrl_t;

endpackage

// ==== cpu8008_sequencer.sv ====
module cpu8008_sequencer (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         ready,
	input  cpu8008_isa_pkg::data_t       bus,
	output cpu8008_isa_pkg::t_state_e    state,
	output logic                         sync,
	output cpu8008_isa_pkg::cycle_type_e cycle_type,
	output cpu8008_ctrl_pkg::cpu_ctrl_t  ctrl
);

	cpu8008_isa_pkg::t_state_e next_state;
	cpu8008_isa_pkg::data_t    ir;
	cpu8008_isa_pkg::reg_idx_t ddd;
	cpu8008_isa_pkg::reg_idx_t sss;
	logic [1:0]                cycle;
	logic [1:0]                last_cycle;
	logic                      is_mvi;
	logic                      is_inr_dcr;
	logic                      is_mov;
	logic                      is_alu;
	logic                      is_rot;
	logic                      is_ret;
	logic                      is_jmp;
	logic                      is_call;

	assign ddd = ir[5:3];
	assign sss = ir[2:0];

	assign is_mvi     = (ir[7:6] == 2'b00) && (ir[2:0] == 3'b110);
	assign is_inr_dcr = (ir[7:6] == 2'b00) && (ir[2:1] == 2'b00) && (ddd != '0); // DDD of 0 is HLT
	assign is_mov     = (ir[7:6] == 2'b11) && (ir != 8'hff);
	assign is_alu     = (ir[7:6] == 2'b10);
	assign is_rot     = (ir[7:5] == 3'b000) && (ir[2:0] == 3'b010);
	assign is_ret     = (ir[7:6] == 2'b00) && (ir[2:0] == 3'b111);
	assign is_jmp     = (ir[7:6] == 2'b01) && (ir[2:0] == 3'b100);
	assign is_call    = (ir[7:6] == 2'b01) && (ir[2:0] == 3'b110);

	// Index of the final machine cycle of the current instruction
	assign last_cycle = (is_jmp || is_call) ? 2'd2 : (is_mvi ? 2'd1 : 2'd0);

	assign sync       = (state == cpu8008_isa_pkg::t1) || (state == cpu8008_isa_pkg::t2);
	assign cycle_type = (cycle == 2'd0) ? cpu8008_isa_pkg::fetch : cpu8008_isa_pkg::read;

	always_comb begin
		case (state)
			cpu8008_isa_pkg::t1:     next_state = cpu8008_isa_pkg::t2;
			cpu8008_isa_pkg::t2,
			cpu8008_isa_pkg::t_wait: next_state = ready ? cpu8008_isa_pkg::t3 : cpu8008_isa_pkg::t_wait;
			cpu8008_isa_pkg::t3:     next_state = cpu8008_isa_pkg::t4;
			cpu8008_isa_pkg::t4:     next_state = cpu8008_isa_pkg::t5;
			default:                 next_state = cpu8008_isa_pkg::t1;
		endcase
	end

	always_comb begin
		ctrl = '0;
		ctrl.bus_src = cpu8008_ctrl_pkg::src_none;
		ctrl.alu.op = cpu8008_isa_pkg::alu_pass;
		case (state)
			cpu8008_isa_pkg::t1: ctrl.bus_src = cpu8008_ctrl_pkg::src_pc_low;
			cpu8008_isa_pkg::t2: begin
				ctrl.bus_src = cpu8008_ctrl_pkg::src_pc_high;
				ctrl.stack.inc_pc = 1'b1;
			end
			cpu8008_isa_pkg::t3: begin
				ctrl.bus_src = cpu8008_ctrl_pkg::src_d_in;
				ctrl.alu.load_tmp_b = (cycle == 2'd1); // Immediate or low address byte
				ctrl.alu.load_tmp_a = (cycle == 2'd2);
			end
			cpu8008_isa_pkg::t4: begin
				if (cycle == 2'd0 && (is_inr_dcr || is_mov || is_alu || is_rot)) begin
					ctrl.bus_src = cpu8008_ctrl_pkg::src_reg_file;
					ctrl.alu.load_tmp_b = 1'b1;
					ctrl.rf.idx = is_inr_dcr ? ddd : (is_rot ? '0 : sss);
				end
				ctrl.stack.pop = (cycle == 2'd0) && is_ret;
				ctrl.stack.push = (cycle == 2'd2) && is_call;
			end
			cpu8008_isa_pkg::t5: begin
				if (cycle == 2'd0 && is_inr_dcr) begin
					ctrl.bus_src = cpu8008_ctrl_pkg::src_alu;
					ctrl.alu.op = ir[0] ? cpu8008_isa_pkg::alu_dec : cpu8008_isa_pkg::alu_inc;
					ctrl.rf.we = 1'b1;
					ctrl.rf.idx = ddd;
				end else if ((cycle == 2'd0 && is_mov) || (cycle == 2'd1 && is_mvi)) begin
					ctrl.bus_src = cpu8008_ctrl_pkg::src_tmp_b;
					ctrl.rf.we = 1'b1;
					ctrl.rf.idx = ddd;
				end else if (cycle == 2'd0 && is_alu) begin
					ctrl.bus_src = cpu8008_ctrl_pkg::src_alu;
					ctrl.alu.op = cpu8008_isa_pkg::alu_op_e'({1'b0, ddd});
					ctrl.alu.write_carry = 1'b1;
					ctrl.rf.we = (ddd != 3'd7); // CMP only sets carry
				end else if (cycle == 2'd0 && is_rot) begin
					ctrl.bus_src = cpu8008_ctrl_pkg::src_alu;
					ctrl.alu.op = cpu8008_isa_pkg::alu_op_e'({2'b11, ir[4:3]});
					ctrl.alu.write_carry = 1'b1;
					ctrl.rf.we = 1'b1;
				end
				ctrl.stack.load_target = (cycle == 2'd2) && (is_jmp || is_call);
			end
			default: ctrl.bus_src = cpu8008_ctrl_pkg::src_none;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= cpu8008_isa_pkg::t1;
			cycle <= 2'd0;
			ir <= '0;
		end else begin
			state <= next_state;
			if (state == cpu8008_isa_pkg::t3 && cycle == 2'd0) begin
				ir <= bus;
			end
			if (state == cpu8008_isa_pkg::t5) begin
				cycle <= (cycle == last_cycle) ? 2'd0 : cycle + 2'd1;
			end
		end
	end

endmodule

// ==== cpu8008_alu.sv ====
`include "cpu8008_config.svh"

module cpu8008_alu (
	input  logic                        clk,
	input  logic                        rst,
	input  cpu8008_isa_pkg::data_t      bus,
	input  cpu8008_isa_pkg::data_t      acc,
	input  cpu8008_ctrl_pkg::alu_ctrl_t ctrl,
	output cpu8008_isa_pkg::data_t      result,
	output cpu8008_isa_pkg::data_t      tmp_a,
	output cpu8008_isa_pkg::data_t      tmp_b
);

	logic                carry;
	logic                carry_next;
	logic                cin;
	logic [`CPU_DATA_W:0] sum;  // Carry out in the top bit
	logic [`CPU_DATA_W:0] diff; // Top bit is the borrow

	// Only ADC and SBB chain the stored carry
	assign cin = carry && (ctrl.op == cpu8008_isa_pkg::alu_adc ||
		ctrl.op == cpu8008_isa_pkg::alu_sbb);

	assign sum  = {1'b0, acc} + {1'b0, tmp_b} + cin;
	assign diff = {1'b0, acc} - {1'b0, tmp_b} - cin;

	always_comb begin
		result = tmp_b;
		carry_next = carry;
		case (ctrl.op)
			cpu8008_isa_pkg::alu_add,
			cpu8008_isa_pkg::alu_adc: {carry_next, result} = sum;
			cpu8008_isa_pkg::alu_sub,
			cpu8008_isa_pkg::alu_sbb,
			cpu8008_isa_pkg::alu_cmp: {carry_next, result} = diff;
			cpu8008_isa_pkg::alu_and: {carry_next, result} = {1'b0, acc & tmp_b};
			cpu8008_isa_pkg::alu_xor: {carry_next, result} = {1'b0, acc ^ tmp_b};
			cpu8008_isa_pkg::alu_or:  {carry_next, result} = {1'b0, acc | tmp_b};
			cpu8008_isa_pkg::alu_inc: result = tmp_b + 1'b1;
			cpu8008_isa_pkg::alu_dec: result = tmp_b - 1'b1;
			cpu8008_isa_pkg::alu_rlc: begin
				result = {tmp_b[`CPU_DATA_W-2:0], tmp_b[`CPU_DATA_W-1]};
				carry_next = tmp_b[`CPU_DATA_W-1];
			end
			cpu8008_isa_pkg::alu_rrc: begin
				result = {tmp_b[0], tmp_b[`CPU_DATA_W-1:1]};
				carry_next = tmp_b[0];
			end
			cpu8008_isa_pkg::alu_ral: begin
				result = {tmp_b[`CPU_DATA_W-2:0], carry}; // Rotate through carry
				carry_next = tmp_b[`CPU_DATA_W-1];
			end
			cpu8008_isa_pkg::alu_rar: begin
				result = {carry, tmp_b[`CPU_DATA_W-1:1]};
				carry_next = tmp_b[0];
			end
			default: result = tmp_b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			tmp_a <= '0;
			tmp_b <= '0;
			carry <= 1'b0;
		end else begin
			if (ctrl.load_tmp_a) begin
				tmp_a <= bus;
			end
			if (ctrl.load_tmp_b) begin
				tmp_b <= bus;
			end
			if (ctrl.write_carry) begin
				carry <= carry_next;
			end
		end
	end

endmodule

// ==== cpu8008_reg_file.sv ====
`include "cpu8008_config.svh"

module cpu8008_reg_file (
	input  logic                       clk,
	input  logic                       rst,
	input  cpu8008_isa_pkg::data_t     bus,
	input  cpu8008_ctrl_pkg::rf_ctrl_t ctrl,
	output cpu8008_isa_pkg::data_t     rd_data,
	output cpu8008_isa_pkg::data_t     acc
);

	cpu8008_isa_pkg::data_t regs [`CPU_NUM_REGS];
	logic                   idx_valid;

	// The last index has no storage behind it
	assign idx_valid = (ctrl.idx < `CPU_NUM_REGS);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.we && idx_valid) begin
			regs[ctrl.idx] <= bus;
		end
	end

	assign rd_data = idx_valid ? regs[ctrl.idx] : '0;
	assign acc     = regs[0]; // Fixed port for the ALU's first operand

endmodule

// ==== cpu8008_addr_stack.sv ====
`include "cpu8008_config.svh"

module cpu8008_addr_stack (
	input  logic                          clk,
	input  logic                          rst,
	input  cpu8008_isa_pkg::addr_t        target,
	input  cpu8008_isa_pkg::cycle_type_e  cycle_type,
	input  cpu8008_ctrl_pkg::stack_ctrl_t ctrl,
	output cpu8008_isa_pkg::data_t        pc_low,
	output cpu8008_isa_pkg::data_t        pc_high
);

	cpu8008_isa_pkg::addr_t     entries [`CPU_STACK_DEPTH];
	cpu8008_isa_pkg::addr_t     pc;
	cpu8008_isa_pkg::stack_ptr_t sp;
	logic                       at_top;
	logic                       at_bottom;

	// The entry under the pointer is the live program counter
	assign pc = entries[sp];

	assign at_top    = (sp == cpu8008_isa_pkg::stack_ptr_t'(`CPU_STACK_DEPTH - 1));
	assign at_bottom = (sp == '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			sp <= '0;
		end else if (ctrl.push && !at_top) begin
			sp <= sp + 1'b1;
		end else if (ctrl.pop && !at_bottom) begin
			sp <= sp - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_STACK_DEPTH; i++) begin
				entries[i] <= '0;
			end
		end else if (ctrl.load_target) begin
			entries[sp] <= target;
		end else if (ctrl.inc_pc) begin
			entries[sp] <= pc + 1'b1;
		end
	end

	assign pc_low = pc[`CPU_DATA_W-1:0];

	// Cycle type rides in the two bits above the upper address bits
	assign pc_high = {cycle_type, pc[`CPU_ADDR_W-1:`CPU_DATA_W]};

endmodule

// ==== cpu8008_core.sv ====
`include "cpu8008_config.svh"

module cpu8008_core (
	input  logic                      clk,
	input  logic                      rst,
	input  cpu8008_isa_pkg::data_t    d_in,
	input  logic                      ready,
	output cpu8008_isa_pkg::data_t    d_out,
	output logic                      sync,
	output cpu8008_isa_pkg::t_state_e state
);

	cpu8008_ctrl_pkg::cpu_ctrl_t  ctrl;
	cpu8008_isa_pkg::cycle_type_e cycle_type;
	cpu8008_isa_pkg::data_t       bus;
	cpu8008_isa_pkg::data_t       rd_data;
	cpu8008_isa_pkg::data_t       acc;
	cpu8008_isa_pkg::data_t       alu_result;
	cpu8008_isa_pkg::data_t       tmp_a;
	cpu8008_isa_pkg::data_t       tmp_b;
	cpu8008_isa_pkg::data_t       pc_low;
	cpu8008_isa_pkg::data_t       pc_high;
	cpu8008_isa_pkg::addr_t       target;

	// Low address byte arrives first, in tmp_b
	assign target = {tmp_a[`CPU_ADDR_W-`CPU_DATA_W-1:0], tmp_b};

	always_comb begin
		case (ctrl.bus_src)
			cpu8008_ctrl_pkg::src_pc_low:   bus = pc_low;
			cpu8008_ctrl_pkg::src_pc_high:  bus = pc_high;
			cpu8008_ctrl_pkg::src_reg_file: bus = rd_data;
			cpu8008_ctrl_pkg::src_alu:      bus = alu_result;
			cpu8008_ctrl_pkg::src_tmp_b:    bus = tmp_b;
			cpu8008_ctrl_pkg::src_d_in:     bus = d_in;
			default:                        bus = '0;
		endcase
	end

	assign d_out = bus;

	cpu8008_sequencer u_sequencer (
		.clk        (clk),
		.rst        (rst),
		.ready      (ready),
		.bus        (bus),
		.state      (state),
		.sync       (sync),
		.cycle_type (cycle_type),
		.ctrl       (ctrl)
	);

	cpu8008_alu u_alu (
		.clk    (clk),
		.rst    (rst),
		.bus    (bus),
		.acc    (acc),
		.ctrl   (ctrl.alu),
		.result (alu_result),
		.tmp_a  (tmp_a),
		.tmp_b  (tmp_b)
	);

	cpu8008_reg_file u_reg_file (
		.clk     (clk),
		.rst     (rst),
		.bus     (bus),
		.ctrl    (ctrl.rf),
		.rd_data (rd_data),
		.acc     (acc)
	);

	cpu8008_addr_stack u_addr_stack (
		.clk        (clk),
		.rst        (rst),
		.target     (target),
		.cycle_type (cycle_type),
		.ctrl       (ctrl.stack),
		.pc_low     (pc_low),
		.pc_high    (pc_high)
	);

endmodule

// ==== cpu8008_assert.sv ====
module cpu8008_assert (
	input logic                      clk,
	input logic                      rst,
	input logic                      ready,
	input logic                      sync,
	input cpu8008_isa_pkg::t_state_e state,
	input cpu8008_isa_pkg::data_t    d_out
);

	int fail_count = 0;

	legal_state: assert property (@(posedge clk) disable iff (rst)
		state inside {cpu8008_isa_pkg::t1, cpu8008_isa_pkg::t2, cpu8008_isa_pkg::t_wait,
			cpu8008_isa_pkg::t3, cpu8008_isa_pkg::t4, cpu8008_isa_pkg::t5})
		else begin
			fail_count++;
			$error("state holds the illegal code %b", state);
		end

	sync_in_address_states: assert property (@(posedge clk) disable iff (rst)
		sync == (state == cpu8008_isa_pkg::t1 || state == cpu8008_isa_pkg::t2))
		else begin
			fail_count++;
			$error("sync is %b in state %b", sync, state);
		end

	// First cycle after reset fetches from address zero, and fetch type is 00
	start_at_zero: assert property (@(posedge clk)
		$fell(rst) |-> (state == cpu8008_isa_pkg::t1 && sync && d_out == '0)
			##1 (state == cpu8008_isa_pkg::t2 && d_out == '0))
		else begin
			fail_count++;
			$error("first machine cycle after reset does not fetch from address zero");
		end

	wait_hold: assert property (@(posedge clk) disable iff (rst)
		(state inside {cpu8008_isa_pkg::t2, cpu8008_isa_pkg::t_wait}) && !ready
			|=> state == cpu8008_isa_pkg::t_wait)
		else begin
			fail_count++;
			$error("state moved on from the wait point while ready was low");
		end

	wait_exit: assert property (@(posedge clk) disable iff (rst)
		(state inside {cpu8008_isa_pkg::t2, cpu8008_isa_pkg::t_wait}) && ready
			|=> state == cpu8008_isa_pkg::t3)
		else begin
			fail_count++;
			$error("state did not reach T3 after ready was high");
		end

	cycle_end: assert property (@(posedge clk) disable iff (rst)
		state == cpu8008_isa_pkg::t5 |=> state == cpu8008_isa_pkg::t1)
		else begin
			fail_count++;
			$error("T5 was not followed by T1");
		end

endmodule

// ==== cpu8008_tb.sv ====
`include "cpu8008_config.svh"

module cpu8008_tb;

	localparam int NUM_INSTR    = 4000;
	localparam int WAIT_LIMIT   = 64;
	localparam int RESET_CYCLES = 5;
	localparam int MEM_SIZE     = 1 << `CPU_ADDR_W;
	localparam int TOP_SP       = `CPU_STACK_DEPTH - 1;

	logic                      clk;
	logic                      rst;
	logic                      ready;
	cpu8008_isa_pkg::data_t    d_in;
	cpu8008_isa_pkg::data_t    d_out;
	logic                      sync;
	cpu8008_isa_pkg::t_state_e state;

	cpu8008_isa_pkg::data_t mem [MEM_SIZE];
	cpu8008_isa_pkg::addr_t bus_addr; // Address as the memory latches it from T1 and T2

	cpu8008_isa_pkg::addr_t model_stack [`CPU_STACK_DEPTH];
	cpu8008_isa_pkg::data_t model_regs [`CPU_NUM_REGS];
	int                     model_sp;
	logic                   model_carry;

	int   checks;
	int   errors;
	int   instr_count;
	int   call_count;
	int   ret_count;
	int   push_sat_count;
	int   pop_sat_count;
	logic aborted;

	cpu8008_core DUT (
		.clk   (clk),
		.rst   (rst),
		.d_in  (d_in),
		.ready (ready),
		.d_out (d_out),
		.sync  (sync),
		.state (state)
	);

	bind cpu8008_core cpu8008_assert u_assert (
		.clk   (clk),
		.rst   (rst),
		.ready (ready),
		.sync  (sync),
		.state (state),
		.d_out (d_out)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	task automatic drive_inputs();
		ready = ($urandom % 4) != 0; // Low about one clock in four
		d_in = mem[bus_addr];
	endtask

	// Ends in the middle of the next clock, where every output has settled
	task automatic next_clock();
		@(posedge clk);
		#1;
		drive_inputs();
		#9;
	endtask

	task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h, expected %h, instruction %0d",
				name, got, exp, instr_count);
		end
	endtask

	function automatic cpu8008_isa_pkg::data_t read_reg(input int idx);
		if (idx < `CPU_NUM_REGS) begin
			return model_regs[idx];
		end
		return '0; // The null register
	endfunction

	task automatic write_reg(input int idx, input cpu8008_isa_pkg::data_t value);
		if (idx < `CPU_NUM_REGS) begin
			model_regs[idx] = value;
		end
	endtask

	task automatic run_machine_cycle(
		input  cpu8008_isa_pkg::cycle_type_e ctype,
		output cpu8008_isa_pkg::data_t       data,
		output cpu8008_isa_pkg::data_t       t5_bus
	);
		cpu8008_isa_pkg::addr_t pc;
		logic                   ready_seen;
		int                     waited;
		pc = model_stack[model_sp];
		data = mem[pc];
		t5_bus = '0;
		compare("state in T1", state, cpu8008_isa_pkg::t1);
		compare("sync in T1", sync, 1'b1);
		compare("d_out in T1", d_out, pc[`CPU_DATA_W-1:0]);
		bus_addr[`CPU_DATA_W-1:0] = d_out;
		next_clock();
		compare("state in T2", state, cpu8008_isa_pkg::t2);
		compare("sync in T2", sync, 1'b1);
		compare("d_out in T2", d_out, {ctype, pc[`CPU_ADDR_W-1:`CPU_DATA_W]});
		bus_addr[`CPU_ADDR_W-1:`CPU_DATA_W] = d_out[`CPU_ADDR_W-`CPU_DATA_W-1:0];
		model_stack[model_sp] = pc + 1'b1; // PC steps at the end of T2
		ready_seen = ready;
		waited = 0;
		next_clock();
		while (state == cpu8008_isa_pkg::t_wait && waited < WAIT_LIMIT) begin
			checks++;
			if (ready_seen) begin
				errors++;
				$display("State went to T_wait although ready was high, instruction %0d",
					instr_count);
			end
			compare("sync in T_wait", sync, 1'b0);
			ready_seen = ready;
			waited++;
			next_clock();
		end
		if (state == cpu8008_isa_pkg::t_wait) begin
			errors++;
			aborted = 1'b1;
			$display("Timeout: no T3 after %0d clocks in T_wait", WAIT_LIMIT);
			return;
		end
		checks++;
		if (!ready_seen) begin
			errors++;
			$display("State left the wait point although ready was low, instruction %0d",
				instr_count);
		end
		compare("state in T3", state, cpu8008_isa_pkg::t3);
		compare("d_out in T3", d_out, data);
		next_clock();
		compare("state in T4", state, cpu8008_isa_pkg::t4);
		compare("sync in T4", sync, 1'b0);
		next_clock();
		compare("state in T5", state, cpu8008_isa_pkg::t5);
		t5_bus = d_out;
		next_clock();
	endtask

	// Accumulator operation on operand b, carry out of bit 8 of sum or borrow
	task automatic model_alu(input logic [2:0] op, input cpu8008_isa_pkg::data_t b,
		output cpu8008_isa_pkg::data_t res);
		cpu8008_isa_pkg::data_t a;
		logic [`CPU_DATA_W:0]   wide;
		a = read_reg(0);
		case (op)
			3'd0: wide = {1'b0, a} + b;
			3'd1: wide = {1'b0, a} + b + model_carry;
			3'd2,
			3'd7: wide = {1'b0, a} - b;
			3'd3: wide = {1'b0, a} - b - model_carry;
			3'd4: wide = {1'b0, a & b};
			3'd5: wide = {1'b0, a ^ b};
			default: wide = {1'b0, a | b};
		endcase
		model_carry = wide[`CPU_DATA_W];
		res = wide[`CPU_DATA_W-1:0];
		if (op != 3'd7) begin
			write_reg(0, res); // CMP keeps the accumulator
		end
	endtask

	task automatic model_rotate(input logic [1:0] kind, output cpu8008_isa_pkg::data_t res);
		cpu8008_isa_pkg::data_t a;
		a = read_reg(0);
		case (kind)
			2'd0: res = {a[6:0], a[7]};
			2'd1: res = {a[0], a[7:1]};
			2'd2: res = {a[6:0], model_carry};
			default: res = {model_carry, a[7:1]};
		endcase
		model_carry = kind[0] ? a[0] : a[7];
		write_reg(0, res);
	endtask

	task automatic run_instruction();
		cpu8008_isa_pkg::data_t op;
		cpu8008_isa_pkg::data_t lo;
		cpu8008_isa_pkg::data_t hi;
		cpu8008_isa_pkg::data_t val;
		cpu8008_isa_pkg::data_t t5_bus;
		int                     ddd;
		int                     sss;
		run_machine_cycle(cpu8008_isa_pkg::fetch, op, t5_bus);
		if (aborted) begin
			return;
		end
		ddd = op[5:3];
		sss = op[2:0];
		case (op[7:6])
			2'b00: begin
				if (op[2:0] == 3'b110) begin // MVI
					run_machine_cycle(cpu8008_isa_pkg::read, val, t5_bus);
					if (aborted) begin
						return;
					end
					write_reg(ddd, val);
					compare("d_out in T5 of MVI", t5_bus, val);
				end else if (op[2:1] == 2'b00 && ddd != 0) begin
					val = op[0] ? read_reg(ddd) - 1'b1 : read_reg(ddd) + 1'b1;
					write_reg(ddd, val);
					compare("d_out in T5 of INR/DCR", t5_bus, val);
				end else if (op[2:0] == 3'b010 && !op[5]) begin
					model_rotate(op[4:3], val);
					compare("d_out in T5 of rotate", t5_bus, val);
				end else if (op[2:0] == 3'b111) begin
					ret_count++;
					if (model_sp == 0) begin
						pop_sat_count++;
					end else begin
						model_sp--;
					end
				end
			end
			2'b01: begin
				if (op[2:0] == 3'b100 || op[2:0] == 3'b110) begin // JMP and CALL
					run_machine_cycle(cpu8008_isa_pkg::read, lo, t5_bus);
					if (aborted) begin
						return;
					end
					run_machine_cycle(cpu8008_isa_pkg::read, hi, t5_bus);
					if (aborted) begin
						return;
					end
					if (op[1]) begin
						call_count++;
						if (model_sp == TOP_SP) begin
							push_sat_count++;
						end else begin
							model_sp++;
						end
					end
					model_stack[model_sp] = {hi[`CPU_ADDR_W-`CPU_DATA_W-1:0], lo};
				end
			end
			2'b10: begin
				model_alu(op[5:3], read_reg(sss), val);
				compare("d_out in T5 of ALU operation", t5_bus, val);
			end
			default: begin
				if (op != 8'hff) begin
					val = read_reg(sss);
					write_reg(ddd, val);
					compare("d_out in T5 of MOV", t5_bus, val);
				end
			end
		endcase
		instr_count++;
	endtask

	initial begin
		void'($urandom(32'h569d_814b));
		rst = 1'b1;
		ready = 1'b0;
		d_in = '0;
		bus_addr = '0;
		checks = 0;
		errors = 0;
		instr_count = 0;
		call_count = 0;
		ret_count = 0;
		push_sat_count = 0;
		pop_sat_count = 0;
		aborted = 1'b0;
		model_sp = 0;
		model_carry = 1'b0;
		for (int i = 0; i < `CPU_STACK_DEPTH; i++) begin
			model_stack[i] = '0;
		end
		for (int i = 0; i < `CPU_NUM_REGS; i++) begin
			model_regs[i] = '0;
		end
		for (int a = 0; a < MEM_SIZE; a++) begin
			mem[a] = cpu8008_isa_pkg::data_t'($urandom);
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		drive_inputs();
		#9;
		compare("state after reset", state, cpu8008_isa_pkg::t1);
		compare("sync after reset", sync, 1'b1);
		while (instr_count < NUM_INSTR && !aborted) begin
			run_instruction();
		end
		errors = errors + DUT.u_assert.fail_count;
		$display("Instructions %0d, calls %0d, returns %0d, full pushes %0d, %s %0d, %s %0d, %s %0d",
			instr_count, call_count, ret_count, push_sat_count,
			"empty pops", pop_sat_count, "checks", checks, "errors", errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== cpu8008.f ====
+incdir+.
cpu8008_isa_pkg.sv
cpu8008_ctrl_pkg.sv
cpu8008_sequencer.sv
cpu8008_alu.sv
cpu8008_reg_file.sv
cpu8008_addr_stack.sv
cpu8008_core.sv
cpu8008_assert.sv
cpu8008_tb.sv

// ==== Bender.yml ====
package:
  name: cpu8008

export_include_dirs:
  - .

sources:
  - files:
      - cpu8008_isa_pkg.sv
      - cpu8008_ctrl_pkg.sv
      - cpu8008_sequencer.sv
      - cpu8008_alu.sv
      - cpu8008_reg_file.sv
      - cpu8008_addr_stack.sv
      - cpu8008_core.sv
  - target: test
    files:
      - cpu8008_assert.sv
      - cpu8008_tb.sv
